/* pma_pkg.sv */
// shared definitions for the PMA unit.
// access width codes, attribute register layout and fault causes.
// AXI4-Lite bus widths, response codes and register map offsets.
package pma_pkg;

  // bus widths of the AXI4-Lite slave port.
  localparam int AXIL_ADDR_W = 8;
  localparam int AXIL_DATA_W = 32;

  // upper bound on region registers, keeps the map below the log registers.
  localparam int MAX_REGS = 16;
  localparam int REG_IDX_W = $clog2(MAX_REGS);

  // register map offsets.
  localparam logic [AXIL_ADDR_W-1:0] REG_BASE = 8'h00;
  localparam logic [AXIL_ADDR_W-1:0] FAULT_STATUS_OFF = 8'h40;
  localparam logic [AXIL_ADDR_W-1:0] FAULT_ADDR_OFF = 8'h44;

  // AXI response codes.
  localparam logic [1:0] RESP_OKAY = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // access width, code 3 is reserved and never allowed.
  typedef enum logic [1:0] {
    ACC_BYTE = 2'd0,
    ACC_HALF = 2'd1,
    ACC_WORD = 2'd2,
    ACC_RSVD = 2'd3
  } acc_width_t;

  // one 16-bit configuration, r sits in bit 0.
  typedef struct packed {
    logic [10:0] reserved;
    acc_width_t  acc_width;
    logic        x;
    logic        w;
    logic        r;
  } pma_cfg_t;

  // one block register, upper half covers address bit 25 set.
  typedef struct packed {
    pma_cfg_t cfg_1;
    pma_cfg_t cfg_0;
  } pma_reg_t;

  // fault cause as reported in the status register.
  typedef enum logic [1:0] {
    CAUSE_NONE  = 2'd0,
    CAUSE_LOAD  = 2'd1,
    CAUSE_STORE = 2'd2,
    CAUSE_FETCH = 2'd3
  } fault_cause_t;

endpackage

/* pma_reg_if.sv */
// register bundle between the bus control and the datapath blocks.
// carries register writes, the attribute array and the fault log fields.
`timescale 1ns/1ps

interface pma_reg_if #(
  parameter int NUM_REGS = 8
);

  // region register write port.
  logic                                wr_en;
  logic [pma_pkg::REG_IDX_W-1:0]       wr_idx;
  pma_pkg::pma_reg_t                   wr_data;
  // full attribute array.
  pma_pkg::pma_reg_t [NUM_REGS-1:0]    regs;
  // fault log clear and contents.
  logic                                log_clr;
  logic                                log_valid;
  pma_pkg::fault_cause_t               log_cause;
  logic [31:0]                         log_addr;

  modport ctrl (output wr_en, wr_idx, wr_data, log_clr,
                input regs, log_valid, log_cause, log_addr);
  modport regfile (input wr_en, wr_idx, wr_data, output regs);
  modport chkr (input regs);
  modport log (output log_valid, log_cause, log_addr, input log_clr);

endinterface

/* pma_check_if.sv */
// core access bundle into the checker.
// request fields go in, one-hot fault flags come out.
`timescale 1ns/1ps

interface pma_check_if;

  // access request.
  logic [31:0]         addr;
  logic                ren;
  logic                wen;
  logic                xen;
  pma_pkg::acc_width_t width;
  // fault flags, at most one set.
  logic                load_fault;
  logic                store_fault;
  logic                fetch_fault;

  // requester side.
  modport core (output addr, ren, wen, xen, width,
                input load_fault, store_fault, fetch_fault);
  // checker side.
  modport pma (input addr, ren, wen, xen, width,
               output load_fault, store_fault, fetch_fault);
  // fault log watches everything.
  modport log (input addr, ren, wen, xen, width,
               load_fault, store_fault, fetch_fault);

endinterface

/* pma_axil_ctrl.sv */
// AXI4-Lite slave control for the PMA register map.
// FSM with idle, write response and read response states.
// offset decode, read data mux and response registers.
`timescale 1ns/1ps

module pma_axil_ctrl #(
  parameter int NUM_REGS = 8
) (
  input  logic                              CLK,
  input  logic                              nRST,
  input  logic [pma_pkg::AXIL_ADDR_W-1:0]   awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [pma_pkg::AXIL_DATA_W-1:0]   wdata,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  input  logic [pma_pkg::AXIL_ADDR_W-1:0]   araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [pma_pkg::AXIL_DATA_W-1:0]   rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready,
  pma_reg_if.ctrl                           regs
);

  localparam int AW = pma_pkg::AXIL_ADDR_W;
  localparam int IW = pma_pkg::REG_IDX_W;

  typedef enum logic [1:0] {ST_IDLE, ST_WRESP, ST_RRESP} state_t;

  state_t                          state;
  logic                            wr_go;
  logic                            rd_go;
  logic                            wr_ok;
  logic                            rd_ok;
  logic [pma_pkg::AXIL_DATA_W-1:0] rd_data;

  // region register hit, index must also exist.
  function automatic logic reg_hit(input logic [AW-1:0] a);
    return (a[AW-1:IW+2] == pma_pkg::REG_BASE[AW-1:IW+2]) && (int'(a[IW+1:2]) < NUM_REGS);
  endfunction

  // word offset match, byte lanes ignored.
  function automatic logic off_hit(input logic [AW-1:0] a, input logic [AW-1:0] off);
    return a[AW-1:2] == off[AW-1:2];
  endfunction

  // write needs both channels, and wins over a read.
  assign wr_go   = (state == ST_IDLE) && awvalid && wvalid;
  assign rd_go   = (state == ST_IDLE) && !(awvalid && wvalid) && arvalid;
  assign awready = wr_go;
  assign wready  = wr_go;
  assign arready = rd_go;

  // side effects fire in the accept cycle, status write clears the log.
  assign wr_ok         = reg_hit(awaddr) || off_hit(awaddr, pma_pkg::FAULT_STATUS_OFF);
  assign regs.wr_en    = wr_go && reg_hit(awaddr);
  assign regs.wr_idx   = awaddr[IW+1:2];
  assign regs.wr_data  = pma_pkg::pma_reg_t'(wdata);
  assign regs.log_clr  = wr_go && off_hit(awaddr, pma_pkg::FAULT_STATUS_OFF);

  // read data mux, unmapped offsets read zero.
  always_comb begin
    rd_data = '0;
    rd_ok   = 1'b1;
    if (reg_hit(araddr)) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        if (araddr[IW+1:2] == IW'(i)) begin
          rd_data = regs.regs[i];
        end
      end
    end else if (off_hit(araddr, pma_pkg::FAULT_STATUS_OFF)) begin
      // cause in bits 2:1, valid in bit 0.
      rd_data = pma_pkg::AXIL_DATA_W'({regs.log_cause, regs.log_valid});
    end else if (off_hit(araddr, pma_pkg::FAULT_ADDR_OFF)) begin
      rd_data = regs.log_addr;
    end else begin
      rd_ok = 1'b0;
    end
  end

  // one outstanding transaction, responses held until taken.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state  <= ST_IDLE;
      bvalid <= 1'b0;
      bresp  <= pma_pkg::RESP_OKAY;
      rvalid <= 1'b0;
      rresp  <= pma_pkg::RESP_OKAY;
      rdata  <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (wr_go) begin
            bvalid <= 1'b1;
            bresp  <= wr_ok ? pma_pkg::RESP_OKAY : pma_pkg::RESP_SLVERR;
            state  <= ST_WRESP;
          end else if (rd_go) begin
            rvalid <= 1'b1;
            rresp  <= rd_ok ? pma_pkg::RESP_OKAY : pma_pkg::RESP_SLVERR;
            rdata  <= rd_data;
            state  <= ST_RRESP;
          end
        end
        ST_WRESP: begin
          if (bready) begin
            bvalid <= 1'b0;
            state  <= ST_IDLE;
          end
        end
        ST_RRESP: begin
          if (rready) begin
            rvalid <= 1'b0;
            state  <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

/* pma_region_file.sv */
// attribute register array for the PMA unit.
// one register per 64 MiB block, written a word at a time.
`timescale 1ns/1ps

module pma_region_file #(
  parameter int NUM_REGS = 8
) (
  input  logic        CLK,
  input  logic        nRST,
  pma_reg_if.regfile  regs
);

  localparam int IW = pma_pkg::REG_IDX_W;

  // register storage.
  pma_pkg::pma_reg_t [NUM_REGS-1:0] regs_q;

  // reset leaves every half all-zero, so all accesses fault.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs_q <= '0;
    end else if (regs.wr_en) begin
      // only the addressed entry changes.
      for (int i = 0; i < NUM_REGS; i++) begin
        if (regs.wr_idx == IW'(i)) begin
          regs_q[i] <= regs.wr_data;
        end
      end
    end
  end

  // whole array goes to the checker and the read path.
  assign regs.regs = regs_q;

endmodule

/* pma_checker.sv */
// combinational PMA check of one core access.
// permission rule and width rule, load before store before fetch.
`timescale 1ns/1ps

module pma_checker #(
  parameter int NUM_REGS = 8
) (
  pma_reg_if.chkr  regs,
  pma_check_if.pma chk
);

  logic [5:0]        blk;
  pma_pkg::pma_reg_t sel_reg;
  pma_pkg::pma_cfg_t cfg;
  logic              too_wide;
  logic              load_bad;
  logic              store_bad;
  logic              fetch_bad;

  // block index from the top six address bits.
  assign blk = chk.addr[31:26];

  // blocks with no register stay all-zero.
  always_comb begin
    sel_reg = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      if (blk == 6'(i)) begin
        sel_reg = regs.regs[i];
      end
    end
  end

  // bit 25 picks the 32 MiB half.
  assign cfg = chk.addr[25] ? sel_reg.cfg_1 : sel_reg.cfg_0;

  // reserved width code never passes.
  assign too_wide = (chk.width == pma_pkg::ACC_RSVD) || (chk.width > cfg.acc_width);

  // each enabled access type fails on its own permission or on width.
  assign load_bad  = chk.ren && (!cfg.r || too_wide);
  assign store_bad = chk.wen && (!cfg.w || too_wide);
  assign fetch_bad = chk.xen && (!cfg.x || too_wide);

  // priority keeps the flags one-hot.
  assign chk.load_fault  = load_bad;
  assign chk.store_fault = !load_bad && store_bad;
  assign chk.fetch_fault = !load_bad && !store_bad && fetch_bad;

endmodule

/* pma_fault_log.sv */
// first-fault log with address and cause.
// holds its entry until software clears it.
`timescale 1ns/1ps

module pma_fault_log (
  input  logic      CLK,
  input  logic      nRST,
  pma_reg_if.log    log,
  pma_check_if.log  chk
);

  logic                  any_fault;
  pma_pkg::fault_cause_t cause_d;
  logic                  valid_q;
  pma_pkg::fault_cause_t cause_q;
  logic [31:0]           addr_q;

  assign any_fault = chk.load_fault || chk.store_fault || chk.fetch_fault;

  // encode the flag that is set.
  always_comb begin
    if (chk.load_fault) begin
      cause_d = pma_pkg::CAUSE_LOAD;
    end else if (chk.store_fault) begin
      cause_d = pma_pkg::CAUSE_STORE;
    end else if (chk.fetch_fault) begin
      cause_d = pma_pkg::CAUSE_FETCH;
    end else begin
      cause_d = pma_pkg::CAUSE_NONE;
    end
  end

  // clear beats a fault in the same cycle.
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid_q <= 1'b0;
      cause_q <= pma_pkg::CAUSE_NONE;
      addr_q  <= '0;
    end else if (log.log_clr) begin
      valid_q <= 1'b0;
      cause_q <= pma_pkg::CAUSE_NONE;
      addr_q  <= '0;
    end else if (!valid_q && any_fault) begin
      valid_q <= 1'b1;
      cause_q <= cause_d;
      addr_q  <= chk.addr;
    end
  end

  assign log.log_valid = valid_q;
  assign log.log_cause = cause_q;
  assign log.log_addr  = addr_q;

endmodule

/* pma_unit.sv */
// top level of the PMA unit.
// AXI4-Lite register port, core check port and fault flags.
// wires the bus control, region file, checker and fault log.
`timescale 1ns/1ps

module pma_unit #(
  parameter int NUM_REGS = 8
) (
  input  logic                              CLK,
  input  logic                              nRST,
  // AXI4-Lite slave.
  input  logic [pma_pkg::AXIL_ADDR_W-1:0]   awaddr,
  input  logic                              awvalid,
  output logic                              awready,
  input  logic [pma_pkg::AXIL_DATA_W-1:0]   wdata,
  input  logic                              wvalid,
  output logic                              wready,
  output logic [1:0]                        bresp,
  output logic                              bvalid,
  input  logic                              bready,
  input  logic [pma_pkg::AXIL_ADDR_W-1:0]   araddr,
  input  logic                              arvalid,
  output logic                              arready,
  output logic [pma_pkg::AXIL_DATA_W-1:0]   rdata,
  output logic [1:0]                        rresp,
  output logic                              rvalid,
  input  logic                              rready,
  // core access under check.
  input  logic [31:0]                       check_addr,
  input  logic                              check_ren,
  input  logic                              check_wen,
  input  logic                              check_xen,
  input  pma_pkg::acc_width_t               check_width,
  output logic                              load_fault,
  output logic                              store_fault,
  output logic                              fetch_fault
);

  pma_reg_if #(.NUM_REGS(NUM_REGS)) reg_if ();
  pma_check_if chk_if ();

  // request side of the check bundle.
  assign chk_if.addr  = check_addr;
  assign chk_if.ren   = check_ren;
  assign chk_if.wen   = check_wen;
  assign chk_if.xen   = check_xen;
  assign chk_if.width = check_width;
  // flags straight out, same cycle.
  assign load_fault   = chk_if.load_fault;
  assign store_fault  = chk_if.store_fault;
  assign fetch_fault  = chk_if.fetch_fault;

  pma_axil_ctrl #(.NUM_REGS(NUM_REGS)) u_ctrl (
    .CLK, .nRST, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready, .regs(reg_if.ctrl)
  );

  pma_region_file #(.NUM_REGS(NUM_REGS)) u_regs (
    .CLK, .nRST, .regs(reg_if.regfile)
  );

  pma_checker #(.NUM_REGS(NUM_REGS)) u_chk (
    .regs(reg_if.chkr), .chk(chk_if.pma)
  );

  pma_fault_log u_log (
    .CLK, .nRST, .log(reg_if.log), .chk(chk_if.log)
  );

endmodule

/* tb_pma_tasks.svh */
// AXI4-Lite driver tasks, value checks and core access checks.
// directed tests for reset, permissions, width, register map,
// fault log and response back-pressure.

// report a failure and end the run.
task automatic stop_with_error(input string msg);
  $display("%s", msg);
  $display("TEST FAIL");
  $fatal(1, "simulation stopped on error");
endtask

task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
  assert (got === exp) else begin
    stop_with_error($sformatf("error: %s expected %0h actual %0h", name, exp, got));
  end
endtask

// level of one handshake signal, picked by name.
function automatic logic handshake_level(input string sig);
  case (sig)
    "awready": return awready;
    "arready": return arready;
    "bvalid":  return bvalid;
    default:   return rvalid;
  endcase
endfunction

// waits on falling edges, where outputs are settled.
task automatic wait_handshake(input string sig);
  int n;
  n = 0;
  @(negedge CLK);
  while (!handshake_level(sig)) begin
    n++;
    if (n > TIMEOUT) begin
      stop_with_error({"timeout, ", sig, " never went high"});
    end
    @(negedge CLK);
  end
endtask

// returns with bvalid high, the handshake closes on the next rising edge.
task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                          output logic [1:0] resp);
  @(posedge CLK);
  awaddr  <= addr;
  wdata   <= data;
  awvalid <= 1'b1;
  wvalid  <= 1'b1;
  wait_handshake("awready");
  // wready pulses with awready.
  check_value("write_wready", 32'h1, 32'(wready));
  @(posedge CLK);
  awvalid <= 1'b0;
  wvalid  <= 1'b0;
  wait_handshake("bvalid");
  resp = bresp;
endtask

task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
  @(posedge CLK);
  araddr  <= addr;
  arvalid <= 1'b1;
  wait_handshake("arready");
  @(posedge CLK);
  arvalid <= 1'b0;
  wait_handshake("rvalid");
  data = rdata;
  resp = rresp;
endtask

task automatic write_expect(input string name, input logic [7:0] addr,
                            input logic [31:0] data, input logic [1:0] exp_resp);
  logic [1:0] resp;
  axil_write(addr, data, resp);
  check_value({name, " bresp"}, 32'(exp_resp), 32'(resp));
endtask

task automatic read_expect(input string name, input logic [7:0] addr,
                           input logic [31:0] exp_data, input logic [1:0] exp_resp);
  logic [31:0] data;
  logic [1:0]  resp;
  axil_read(addr, data, resp);
  check_value({name, " rresp"}, 32'(exp_resp), 32'(resp));
  check_value({name, " rdata"}, exp_data, data);
endtask

// one 16-bit configuration, r in bit 0, x in bit 2, width in 4:3.
function automatic logic [15:0] make_cfg(input logic [2:0] perm, input logic [1:0] wd);
  return {11'b0, wd, perm};
endfunction

function automatic logic [31:0] rand_addr(input logic [5:0] blk, input logic half);
  logic [31:0] r;
  r = $urandom();
  return {blk, half, r[24:0]};
endfunction

// expected {fetch, store, load} flags from the shadow registers.
function automatic logic [2:0] predict_flags(input logic [31:0] a, input logic [2:0] kind,
                                             input logic [1:0] wd);
  logic [31:0] word;
  logic [15:0] cfg;
  logic        wide;
  logic        lb;
  logic        sb;
  logic        fb;
  word = model[a[31:26]];
  cfg  = a[25] ? word[31:16] : word[15:0];
  // code 3 is wider than any width a region allows.
  wide = (wd == 2'd3) || (wd > cfg[4:3]);
  lb   = kind[0] && (!cfg[0] || wide);
  sb   = kind[1] && (!cfg[1] || wide);
  fb   = kind[2] && (!cfg[2] || wide);
  return {fb && !lb && !sb, sb && !lb, lb};
endfunction

// kind is {x, w, r}, flags are checked half a cycle later, then the port idles.
task automatic access_expect(input string name, input logic [31:0] addr,
                             input logic [2:0] kind, input logic [1:0] wd,
                             input logic [2:0] exp);
  @(posedge CLK);
  check_addr  <= addr;
  check_ren   <= kind[0];
  check_wen   <= kind[1];
  check_xen   <= kind[2];
  check_width <= pma_pkg::acc_width_t'(wd);
  @(negedge CLK);
  check_value(name, {29'b0, exp}, {29'b0, fetch_fault, store_fault, load_fault});
  @(posedge CLK);
  check_ren <= 1'b0;
  check_wen <= 1'b0;
  check_xen <= 1'b0;
endtask

task automatic reset_defaults();
  logic [31:0] a;
  for (int i = 0; i < NUM_REGS; i++) begin
    read_expect("reset_read", 8'(4 * i), 32'h0, pma_pkg::RESP_OKAY);
  end
  // load, store, fetch each fault on its own.
  for (int k = 0; k < 3; k++) begin
    a = rand_addr(6'($urandom_range(63)), 1'($urandom_range(1)));
    access_expect("reset_access", a, 3'b001 << k, 2'd0, 3'b001 << k);
  end
endtask

task automatic permission_rule();
  logic [15:0] lo;
  logic [15:0] hi;
  logic [31:0] a;
  logic [1:0]  wd;
  // lower half gets perm i, upper half the complement.
  for (int i = 0; i < NUM_REGS; i++) begin
    lo = make_cfg(3'(i), 2'd2);
    hi = make_cfg(3'(7 - i), 2'd2);
    model[i] = {hi, lo};
    write_expect("perm_write", 8'(4 * i), {hi, lo}, pma_pkg::RESP_OKAY);
  end
  // every mix of enables, several at once to hit the priority.
  for (int i = 0; i < NUM_REGS; i++) begin
    for (int h = 0; h < 2; h++) begin
      for (int k = 0; k < 8; k++) begin
        a  = rand_addr(6'(i), 1'(h));
        wd = 2'($urandom_range(2));
        access_expect("perm_access", a, 3'(k), wd, predict_flags(a, 3'(k), wd));
      end
    end
  end
endtask

task automatic width_rule();
  logic [31:0] a;
  model[3] = {make_cfg(3'b111, 2'd1), make_cfg(3'b111, 2'd1)};
  write_expect("width_write", 8'h0c, model[3], pma_pkg::RESP_OKAY);
  a = rand_addr(6'd3, 1'($urandom_range(1)));
  access_expect("width_byte_load", a, 3'b001, 2'd0, 3'b000);
  access_expect("width_half_load", a, 3'b001, 2'd1, 3'b000);
  access_expect("width_word_load", a, 3'b001, 2'd2, 3'b001);
  // reserved code fails every access type.
  access_expect("width_rsvd_load", a, 3'b001, 2'd3, 3'b001);
  access_expect("width_rsvd_store", a, 3'b010, 2'd3, 3'b010);
  access_expect("width_rsvd_fetch", a, 3'b100, 2'd3, 3'b100);
  // a region marked with the reserved code still rejects reserved accesses.
  model[4] = {make_cfg(3'b111, 2'd3), make_cfg(3'b111, 2'd3)};
  write_expect("width_rsvd_write", 8'h10, model[4], pma_pkg::RESP_OKAY);
  a = rand_addr(6'd4, 1'($urandom_range(1)));
  for (int k = 0; k < 3; k++) begin
    access_expect("width_rsvd_region", a, 3'b001 << k, 2'd3, 3'b001 << k);
  end
endtask

task automatic register_map();
  logic [31:0] v;
  logic [31:0] a;
  for (int i = 0; i < NUM_REGS; i++) begin
    v = $urandom();
    model[i] = v;
    write_expect("map_write", 8'(4 * i), v, pma_pkg::RESP_OKAY);
  end
  for (int i = 0; i < NUM_REGS; i++) begin
    read_expect("map_readback", 8'(4 * i), model[i], pma_pkg::RESP_OKAY);
  end
  write_expect("map_idx_write", 8'(4 * NUM_REGS), 32'hffff_ffff, pma_pkg::RESP_SLVERR);
  read_expect("map_idx_read", 8'(4 * NUM_REGS), 32'h0, pma_pkg::RESP_SLVERR);
  write_expect("map_unmapped_write", 8'h48, 32'hffff_ffff, pma_pkg::RESP_SLVERR);
  read_expect("map_unmapped_read", 8'h48, 32'h0, pma_pkg::RESP_SLVERR);
  read_expect("map_high_read", 8'hf0, 32'h0, pma_pkg::RESP_SLVERR);
  write_expect("map_addr_write", pma_pkg::FAULT_ADDR_OFF, 32'hffff_ffff,
               pma_pkg::RESP_SLVERR);
  // rejected writes leave the array alone.
  for (int i = 0; i < NUM_REGS; i++) begin
    read_expect("map_unchanged", 8'(4 * i), model[i], pma_pkg::RESP_OKAY);
  end
  for (int k = 0; k < 3; k++) begin
    a = rand_addr(6'($urandom_range(63, NUM_REGS)), 1'($urandom_range(1)));
    access_expect("map_no_region", a, 3'b001 << k, 2'd0, 3'b001 << k);
  end
endtask

task automatic fault_log_capture();
  logic [31:0] a1;
  logic [31:0] a2;
  logic [31:0] a3;
  write_expect("log_clear", pma_pkg::FAULT_STATUS_OFF, 32'h0, pma_pkg::RESP_OKAY);
  read_expect("log_empty", pma_pkg::FAULT_STATUS_OFF, 32'h0, pma_pkg::RESP_OKAY);
  // store fault first, then a load fault that must not replace it.
  a1 = rand_addr(6'd63, 1'b0);
  a2 = rand_addr(6'(NUM_REGS), 1'b1);
  access_expect("log_first", a1, 3'b010, 2'd2, 3'b010);
  access_expect("log_second", a2, 3'b001, 2'd0, 3'b001);
  read_expect("log_status", pma_pkg::FAULT_STATUS_OFF, {29'b0, 2'd2, 1'b1},
              pma_pkg::RESP_OKAY);
  read_expect("log_addr", pma_pkg::FAULT_ADDR_OFF, a1, pma_pkg::RESP_OKAY);
  write_expect("log_clear", pma_pkg::FAULT_STATUS_OFF, 32'hffff_ffff, pma_pkg::RESP_OKAY);
  read_expect("log_cleared", pma_pkg::FAULT_STATUS_OFF, 32'h0, pma_pkg::RESP_OKAY);
  a3 = rand_addr(6'($urandom_range(63, NUM_REGS)), 1'($urandom_range(1)));
  access_expect("log_third", a3, 3'b100, 2'd0, 3'b100);
  read_expect("log_new_status", pma_pkg::FAULT_STATUS_OFF, {29'b0, 2'd3, 1'b1},
              pma_pkg::RESP_OKAY);
  read_expect("log_new_addr", pma_pkg::FAULT_ADDR_OFF, a3, pma_pkg::RESP_OKAY);
endtask

task automatic response_backpressure();
  logic [31:0] v;
  logic [1:0]  resp0;
  logic [31:0] data0;
  int          span;
  v = $urandom();
  model[1] = v;
  // write with bready low, a read queued behind it.
  @(posedge CLK);
  bready  <= 1'b0;
  awaddr  <= 8'h04;
  wdata   <= v;
  awvalid <= 1'b1;
  wvalid  <= 1'b1;
  wait_handshake("awready");
  @(posedge CLK);
  awvalid <= 1'b0;
  wvalid  <= 1'b0;
  araddr  <= 8'h04;
  arvalid <= 1'b1;
  wait_handshake("bvalid");
  resp0 = bresp;
  check_value("bp_bresp", 32'(pma_pkg::RESP_OKAY), 32'(resp0));
  span = $urandom_range(8, 1);
  repeat (span) begin
    @(negedge CLK);
    check_value("bp_bvalid_held", 32'h1, 32'(bvalid));
    check_value("bp_bresp_stable", 32'(resp0), 32'(bresp));
    check_value("bp_read_blocked", 32'h0, 32'(arready));
  end
  // release the write response, hold the read response next.
  @(posedge CLK);
  bready <= 1'b1;
  rready <= 1'b0;
  wait_handshake("arready");
  check_value("bp_bvalid_done", 32'h0, 32'(bvalid));
  // the same write waits behind the read response.
  @(posedge CLK);
  arvalid <= 1'b0;
  awvalid <= 1'b1;
  wvalid  <= 1'b1;
  wait_handshake("rvalid");
  data0 = rdata;
  check_value("bp_rdata", v, data0);
  check_value("bp_rresp", 32'(pma_pkg::RESP_OKAY), 32'(rresp));
  span = $urandom_range(8, 1);
  repeat (span) begin
    @(negedge CLK);
    check_value("bp_rvalid_held", 32'h1, 32'(rvalid));
    check_value("bp_rdata_stable", data0, rdata);
    check_value("bp_write_blocked", 32'h0, 32'(awready));
  end
  @(posedge CLK);
  rready <= 1'b1;
  wait_handshake("awready");
  check_value("bp_rvalid_done", 32'h0, 32'(rvalid));
  @(posedge CLK);
  awvalid <= 1'b0;
  wvalid  <= 1'b0;
  wait_handshake("bvalid");
  check_value("bp_second_bresp", 32'(pma_pkg::RESP_OKAY), 32'(bresp));
endtask

/* tb_pma_unit.sv */
// testbench top for the PMA unit.
// clock, reset, DUT instance and the directed test sequence.
`timescale 1ns/1ps

module tb_pma_unit;

  localparam int NUM_REGS = 8;
  // falling edges to wait for any handshake.
  localparam int TIMEOUT = 64;

  logic                            CLK = 1'b0;
  logic                            nRST;
  logic [pma_pkg::AXIL_ADDR_W-1:0] awaddr;
  logic                            awvalid;
  logic                            awready;
  logic [pma_pkg::AXIL_DATA_W-1:0] wdata;
  logic                            wvalid;
  logic                            wready;
  logic [1:0]                      bresp;
  logic                            bvalid;
  logic                            bready;
  logic [pma_pkg::AXIL_ADDR_W-1:0] araddr;
  logic                            arvalid;
  logic                            arready;
  logic [pma_pkg::AXIL_DATA_W-1:0] rdata;
  logic [1:0]                      rresp;
  logic                            rvalid;
  logic                            rready;
  logic [31:0]                     check_addr;
  logic                            check_ren;
  logic                            check_wen;
  logic                            check_xen;
  pma_pkg::acc_width_t             check_width;
  logic                            load_fault;
  logic                            store_fault;
  logic                            fetch_fault;

  // shadow of the region registers, indexed by block.
  // blocks without a register stay zero.
  logic [31:0] model [64];

  pma_unit #(.NUM_REGS(NUM_REGS)) uut (
    .CLK, .nRST, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .check_addr, .check_ren, .check_wen, .check_xen, .check_width,
    .load_fault, .store_fault, .fetch_fault
  );

  `include "tb_pma_tasks.svh"

  // 20 ns clock.
  always #10 CLK = ~CLK;

  initial begin
    void'($urandom(32'h8c39));
    for (int i = 0; i < 64; i++) begin
      model[i] = '0;
    end
    // idle bus, responses taken at once by default.
    nRST        <= 1'b0;
    awaddr      <= '0;
    awvalid     <= 1'b0;
    wdata       <= '0;
    wvalid      <= 1'b0;
    bready      <= 1'b1;
    araddr      <= '0;
    arvalid     <= 1'b0;
    rready      <= 1'b1;
    check_addr  <= '0;
    check_ren   <= 1'b0;
    check_wen   <= 1'b0;
    check_xen   <= 1'b0;
    check_width <= pma_pkg::ACC_BYTE;
    repeat (4) @(posedge CLK);
    nRST <= 1'b1;
    @(posedge CLK);
    reset_defaults();
    permission_rule();
    width_rule();
    register_map();
    fault_log_capture();
    response_backpressure();
    $display("TEST PASS");
    $finish;
  end

endmodule

/* pma_unit.f */
+incdir+.
pma_pkg.sv
pma_reg_if.sv
pma_check_if.sv
pma_axil_ctrl.sv
pma_region_file.sv
pma_checker.sv
pma_fault_log.sv
pma_unit.sv
tb_pma_unit.sv

/* Bender.yml */
package:
  name: pma_unit

sources:
  - files:
      - pma_pkg.sv
      - pma_reg_if.sv
      - pma_check_if.sv
      - pma_axil_ctrl.sv
      - pma_region_file.sv
      - pma_checker.sv
      - pma_fault_log.sv
      - pma_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pma_unit.sv
